/* hw/soc_pkg.sv */
package soc_pkg;

   // uart bit period in clock cycles
   localparam int CLKS_PER_BIT = 8;

   // internal reset hold after the board pin is released
   localparam int RST_HOLD = 8;

   // external memory geometry and read latency
   localparam int ADDR_W  = 8;
   localparam int DATA_W  = 16;
   localparam int MEM_LAT = 4;

   // command opcodes and response codes
   localparam logic [7:0] OP_WRITE = 8'h57;
   localparam logic [7:0] OP_READ  = 8'h52;
   localparam logic [7:0] ACK_BYTE = 8'h4B;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // one command frame, either as received bytes or as decoded fields
   // raw[0] is the first byte on the wire and lines up with the opcode
   typedef union packed {
      logic [0:3][7:0] raw;
      struct packed {
         logic [7:0] opcode;
         addr_t      addr;
         logic [7:0] data_hi;
         logic [7:0] data_lo;
      } fields;
   } cmd_frame_t;

endpackage

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if (
   input logic clk_i
);
   import soc_pkg::*;

   logic  req;
   logic  we;
   addr_t addr;
   data_t wdata;
   data_t rdata;
   logic  rvalid;

   // command side issues single-cycle requests
   modport ctrl (
      output req,
      output we,
      output addr,
      output wdata,
      input  rdata,
      input  rvalid
   );

   // memory side returns read data after a fixed latency
   modport mem (
      input  clk_i,
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output rdata,
      output rvalid
   );

endinterface

/* hw/reset_pulse_gen.sv */
`timescale 1ns/1ps

module reset_pulse_gen (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic rst_o
);
   import soc_pkg::*;

   logic [$clog2(RST_HOLD)-1:0] hold_cnt;
   logic                        hold_done;

   assign hold_done = (hold_cnt == $bits(hold_cnt)'(RST_HOLD - 1));

   // assert at once from the pin, release only after the hold count
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_cnt <= '0;
         rst_o    <= 1'b1;
      end else if (rst_o) begin
         if (hold_done) begin
            rst_o <= 1'b0;
         end else begin
            hold_cnt <= hold_cnt + 1'b1;
         end
      end
   end

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       rxd_i,
   output logic [7:0] data_o,
   output logic       valid_o
);
   import soc_pkg::*;

   enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state_q;

   logic                            rxd_meta;
   logic                            rxd_sync;
   logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
   logic [2:0]                      bit_idx;
   logic [7:0]                      shift_q;
   logic                            half_bit;
   logic                            full_bit;

   assign half_bit = (clk_cnt == $bits(clk_cnt)'(CLKS_PER_BIT / 2 - 1));
   assign full_bit = (clk_cnt == $bits(clk_cnt)'(CLKS_PER_BIT - 1));
   assign data_o   = shift_q;

   // line idles high, so the synchronizer resets to one
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd_i;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= RX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         shift_q <= '0;
         valid_o <= 1'b0;
      end else begin
         valid_o <= 1'b0;
         case (state_q)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rxd_sync) begin
                  state_q <= RX_START;
               end
            end
            // recheck the start bit at its middle to reject glitches
            RX_START: begin
               if (half_bit) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state_q <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  clk_cnt <= '0;
                  shift_q <= {rxd_sync, shift_q[7:1]};
                  if (bit_idx == 3'd7) begin
                     state_q <= RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (full_bit) begin
                  clk_cnt <= '0;
                  // framing error drops the byte
                  valid_o <= rxd_sync;
                  state_q <= RX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       start_i,
   input  logic [7:0] data_i,
   output logic       txd_o,
   output logic       busy_o
);
   import soc_pkg::*;

   // stop, data and start bits, sent from bit 0 upward
   logic [9:0]                      shift_q;
   logic [3:0]                      bit_cnt;
   logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
   logic                            bit_end;

   assign bit_end = (clk_cnt == $bits(clk_cnt)'(CLKS_PER_BIT - 1));
   assign txd_o   = shift_q[0];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         shift_q <= '1;
         bit_cnt <= '0;
         clk_cnt <= '0;
         busy_o  <= 1'b0;
      end else if (!busy_o) begin
         if (start_i) begin
            shift_q <= {1'b1, data_i, 1'b0};
            bit_cnt <= '0;
            clk_cnt <= '0;
            busy_o  <= 1'b1;
         end
      end else if (bit_end) begin
         clk_cnt <= '0;
         // ones shifted in keep the line high once the frame is out
         shift_q <= {1'b1, shift_q[9:1]};
         if (bit_cnt == 4'd9) begin
            busy_o <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

endmodule

/* hw/cmd_ctrl.sv */
`timescale 1ns/1ps

module cmd_ctrl (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic [7:0] rx_data_i,
   input  logic       rx_valid_i,
   output logic [7:0] tx_data_o,
   output logic       tx_start_o,
   input  logic       tx_busy_i,
   mem_bus_if.ctrl    bus,
   output logic       trap_o
);
   import soc_pkg::*;

   enum logic [2:0] {ST_COLLECT, ST_DECODE, ST_WAIT, ST_SEND, ST_TRAP} state_q;

   cmd_frame_t frame_q;
   logic [1:0] byte_cnt;
   data_t      resp_q;
   logic [1:0] resp_cnt;
   logic       send_now;

   // tx_start_o guards the cycle before busy rises
   assign send_now = (state_q == ST_SEND) && (resp_cnt != 2'd0) &&
                     !tx_busy_i && !tx_start_o;

   assign bus.addr  = frame_q.fields.addr;
   assign bus.wdata = {frame_q.fields.data_hi, frame_q.fields.data_lo};
   assign trap_o    = (state_q == ST_TRAP);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= ST_COLLECT;
         byte_cnt   <= '0;
         resp_cnt   <= '0;
         tx_start_o <= 1'b0;
         bus.req    <= 1'b0;
         bus.we     <= 1'b0;
      end else begin
         tx_start_o <= 1'b0;
         bus.req    <= 1'b0;
         case (state_q)
            ST_COLLECT: begin
               if (rx_valid_i) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 2'd3) begin
                     state_q <= ST_DECODE;
                  end
               end
            end
            ST_DECODE: begin
               if (frame_q.fields.opcode == OP_WRITE) begin
                  bus.req  <= 1'b1;
                  bus.we   <= 1'b1;
                  resp_cnt <= 2'd1;
                  state_q  <= ST_SEND;
               end else if (frame_q.fields.opcode == OP_READ) begin
                  bus.req <= 1'b1;
                  bus.we  <= 1'b0;
                  state_q <= ST_WAIT;
               end else begin
                  state_q <= ST_TRAP;
               end
            end
            ST_WAIT: begin
               if (bus.rvalid) begin
                  resp_cnt <= 2'd2;
                  state_q  <= ST_SEND;
               end
            end
            ST_SEND: begin
               if (resp_cnt == 2'd0) begin
                  state_q <= ST_COLLECT;
               end else if (send_now) begin
                  tx_start_o <= 1'b1;
                  resp_cnt   <= resp_cnt - 1'b1;
               end
            end
            // only a reset leaves the trap
            ST_TRAP: state_q <= ST_TRAP;
            default: state_q <= ST_COLLECT;
         endcase
      end
   end

   // frame bytes and queued response, high byte goes out first
   always_ff @(posedge clk_i) begin
      if (state_q == ST_COLLECT && rx_valid_i) begin
         frame_q.raw[byte_cnt] <= rx_data_i;
      end
      if (state_q == ST_DECODE) begin
         resp_q <= {ACK_BYTE, 8'h00};
      end else if (state_q == ST_WAIT && bus.rvalid) begin
         resp_q <= bus.rdata;
      end else if (send_now) begin
         resp_q <= {resp_q[7:0], 8'h00};
      end
      if (send_now) begin
         tx_data_o <= resp_q[15:8];
      end
   end

endmodule

/* hw/ext_mem.sv */
`timescale 1ns/1ps

module ext_mem (
   mem_bus_if.mem bus,
   input logic    rst_i
);
   import soc_pkg::*;

   data_t              mem_q [2**ADDR_W];
   data_t              data_pipe [MEM_LAT];
   logic [MEM_LAT-1:0] vld_pipe;
   logic               rd_req;

   assign rd_req     = bus.req && !bus.we;
   assign bus.rvalid = vld_pipe[MEM_LAT-1];
   assign bus.rdata  = data_pipe[MEM_LAT-1];

   // write lands at the edge that samples req
   always_ff @(posedge bus.clk_i) begin
      if (bus.req && bus.we) begin
         mem_q[bus.addr] <= bus.wdata;
      end
   end

   // read data moves one stage per cycle so reads can overlap
   always_ff @(posedge bus.clk_i) begin
      if (rd_req) begin
         data_pipe[0] <= mem_q[bus.addr];
      end
      for (int i = 1; i < MEM_LAT; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge bus.clk_i or posedge rst_i) begin
      if (rst_i) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[MEM_LAT-2:0], rd_req};
      end
   end

endmodule

/* hw/soc_fpga_wrapper.sv */
`timescale 1ns/1ps

module soc_fpga_wrapper (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   logic       rst;
   logic [7:0] rx_data;
   logic       rx_valid;
   logic [7:0] tx_data;
   logic       tx_start;
   logic       tx_busy;

   mem_bus_if mem_bus (.clk_i(clk_i));

   // board reset pin is not trusted, stretch it
   reset_pulse_gen i_reset_gen (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .rst_o   (rst)
   );

   uart_rx i_uart_rx (
      .clk_i   (clk_i),
      .rst_i   (rst),
      .rxd_i   (uart_rxd_i),
      .data_o  (rx_data),
      .valid_o (rx_valid)
   );

   uart_tx i_uart_tx (
      .clk_i   (clk_i),
      .rst_i   (rst),
      .start_i (tx_start),
      .data_i  (tx_data),
      .txd_o   (uart_txd_o),
      .busy_o  (tx_busy)
   );

   // takes the place of the processor
   cmd_ctrl i_cmd_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst),
      .rx_data_i  (rx_data),
      .rx_valid_i (rx_valid),
      .tx_data_o  (tx_data),
      .tx_start_o (tx_start),
      .tx_busy_i  (tx_busy),
      .bus        (mem_bus.ctrl),
      .trap_o     (trap_o)
   );

   ext_mem i_ext_mem (
      .bus   (mem_bus.mem),
      .rst_i (rst)
   );

endmodule

/* tb/soc_assert.sv */
`timescale 1ns/1ps

module soc_assert (
   input logic clk_i,
   input logic rst_i,
   input logic txd_i,
   input logic trap_i,
   input logic req_i,
   input logic we_i,
   input logic rvalid_i
);
   import soc_pkg::*;

   logic rd_req;

   assign rd_req = req_i && !we_i;

   // line idles high while the system is held in reset
   txd_idle_in_reset: assert property (@(posedge clk_i) rst_i |-> txd_i)
      else $error("txd low during internal reset");

   // only the internal reset may clear the trap
   trap_sticky: assert property (@(posedge clk_i) trap_i && !rst_i |=> trap_i || rst_i)
      else $error("trap dropped without a reset");

   read_gives_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_req |-> ##MEM_LAT rvalid_i)
      else $error("rvalid missing after read request");

   rvalid_needs_read: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> $past(rd_req, MEM_LAT))
      else $error("rvalid without a read request");

endmodule

bind soc_fpga_wrapper soc_assert i_soc_assert (
   .clk_i    (clk_i),
   .rst_i    (rst),
   .txd_i    (uart_txd_o),
   .trap_i   (trap_o),
   .req_i    (mem_bus.req),
   .we_i     (mem_bus.we),
   .rvalid_i (mem_bus.rvalid)
);

/* tb/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
   import soc_pkg::*;

   localparam int NUM_WRITES = 20;
   // basic pair, writes, read back, illegal frame, pair after reset
   localparam int NUM_FRAMES = 2 + NUM_WRITES + (NUM_WRITES + 1) + 1 + 2;
   localparam int FRAME_CYC  = 4 * 10 * CLKS_PER_BIT;
   localparam int MAX_CYCLES = NUM_FRAMES * 6 * 10 * CLKS_PER_BIT * 2;

   // expected reply: byte count and up to two bytes, first one high
   typedef struct packed {
      logic [1:0] count;
      data_t      bytes;
   } resp_t;

   logic clk_i;
   logic rst_n_i;
   logic uart_rxd_i;
   logic uart_txd_o;
   logic trap_o;

   logic [16:0] lfsr_q = 17'd76512;
   data_t       model_mem [2**ADDR_W];
   bit          model_written [2**ADDR_W];
   logic [7:0]  act_q [$];
   resp_t       exp_q [$];
   string       name_q [$];
   int          checked_cnt;
   int          mismatch_cnt;
   int          missing_cnt;
   int          protocol_cnt;
   int          cycle_cnt;

   soc_fpga_wrapper i_dut (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .uart_rxd_i (uart_rxd_i),
      .uart_txd_o (uart_txd_o),
      .trap_o     (trap_o)
   );

   always #2 clk_i = ~clk_i;

   // fibonacci lfsr x^17 + x^14 + 1, one step per bit taken
   function automatic logic [15:0] take_bits(int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[16] ^ lfsr_q[13];
         lfsr_q = {lfsr_q[15:0], fb};
         r      = {r[14:0], fb};
      end
      return r;
   endfunction

   // memory model, updated by writes, answers reads of written words
   function automatic resp_t ref_frame(cmd_frame_t f);
      resp_t r;
      r.count = 2'd0;
      r.bytes = '0;
      if (f.fields.opcode == OP_WRITE) begin
         model_mem[f.fields.addr]     = {f.fields.data_hi, f.fields.data_lo};
         model_written[f.fields.addr] = 1'b1;
         r.count = 2'd1;
         r.bytes = {ACK_BYTE, 8'h00};
      end else if (f.fields.opcode == OP_READ) begin
         r.count = 2'd2;
         r.bytes = model_mem[f.fields.addr];
      end
      return r;
   endfunction

   task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
      if (act !== exp) begin
         $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_data(string name, data_t exp, data_t act);
      if (act !== exp) begin
         $display("mismatch %s: expected %04h, actual %04h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_trap(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("mismatch %s: expected trap %0b, actual %0b", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic apply_reset();
      rst_n_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      repeat (RST_HOLD + 4) @(posedge clk_i);
   endtask

   // start, eight data bits lsb first, stop
   task automatic send_byte(logic [7:0] b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};
      repeat (10) begin
         @(posedge clk_i);
         #1;
         uart_rxd_i = bits[0];
         bits = {1'b1, bits[9:1]};
         repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
      end
   endtask

   task automatic send_frame(cmd_frame_t f);
      send_byte(f.raw[0]);
      send_byte(f.raw[1]);
      send_byte(f.raw[2]);
      send_byte(f.raw[3]);
   endtask

   // host side: send, queue the expected reply, wait until it is compared
   task automatic run_frame(string name, logic [7:0] op, addr_t addr, data_t data);
      cmd_frame_t f;
      int         target;
      f.fields.opcode  = op;
      f.fields.addr    = addr;
      f.fields.data_hi = data[15:8];
      f.fields.data_lo = data[7:0];
      target = checked_cnt + 1;
      send_frame(f);
      exp_q.push_back(ref_frame(f));
      name_q.push_back(name);
      while (checked_cnt < target) begin
         @(negedge clk_i);
      end
   endtask

   task automatic wait_byte(output logic [7:0] b, output bit ok);
      int n;
      n  = 0;
      b  = '0;
      ok = 1'b0;
      while (act_q.size() == 0 && n < FRAME_CYC) begin
         @(negedge clk_i);
         n++;
      end
      if (act_q.size() != 0) begin
         b  = act_q.pop_front();
         ok = 1'b1;
      end
   endtask

   task automatic check_idle(string name, int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         if (uart_txd_o !== 1'b1) begin
            $display("%s: txd left the idle level", name);
            protocol_cnt++;
            break;
         end
      end
   endtask

   // uart monitor on txd, samples at bit middles
   initial begin : txd_monitor
      logic [7:0] b;
      forever begin
         @(negedge clk_i);
         if (rst_n_i === 1'b1 && uart_txd_o === 1'b0) begin
            b = '0;
            repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
            repeat (8) begin
               repeat (CLKS_PER_BIT) @(negedge clk_i);
               b = {uart_txd_o, b[7:1]};
            end
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            if (uart_txd_o !== 1'b1) begin
               $display("stop bit on txd was low");
               protocol_cnt++;
            end
            act_q.push_back(b);
         end
      end
   end

   initial begin : compare_resp
      resp_t      exp;
      string      name;
      logic [7:0] hi;
      logic [7:0] lo;
      bit         hi_ok;
      bit         lo_ok;
      forever begin
         while (exp_q.size() == 0) begin
            @(negedge clk_i);
         end
         exp   = exp_q.pop_front();
         name  = name_q.pop_front();
         lo    = '0;
         lo_ok = 1'b1;
         wait_byte(hi, hi_ok);
         if (hi_ok && exp.count == 2'd2) begin
            wait_byte(lo, lo_ok);
         end
         if (!hi_ok || !lo_ok) begin
            $display("%s: response byte did not arrive within a frame time", name);
            missing_cnt++;
         end else if (exp.count == 2'd1) begin
            check_byte(name, exp.bytes[15:8], hi);
         end else begin
            check_data(name, exp.bytes, {hi, lo});
         end
         checked_cnt++;
      end
   end

   initial begin : watchdog
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles", MAX_CYCLES);
      $display("errors: mismatch %0d, missing %0d, protocol %0d",
               mismatch_cnt, missing_cnt, protocol_cnt);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : stimulus
      addr_t      wr_addr;
      addr_t      group_addr;
      addr_t      rd_addr;
      data_t      wr_data;
      cmd_frame_t bad;
      clk_i      = 1'b0;
      uart_rxd_i = 1'b1;
      apply_reset();

      check_idle("after_reset", 2 * CLKS_PER_BIT);
      check_trap("after_reset", 1'b0, trap_o);

      run_frame("write_basic", OP_WRITE, 8'h3C, 16'hA55A);
      run_frame("read_basic", OP_READ, 8'h3C, '0);

      // every fifth write goes back to an earlier address
      for (int i = 0; i < NUM_WRITES; i++) begin
         if (i % 5 == 4) begin
            wr_addr = group_addr;
         end else begin
            wr_addr = addr_t'(take_bits(ADDR_W));
         end
         if (i % 5 == 0) begin
            group_addr = wr_addr;
         end
         wr_data = take_bits(DATA_W);
         run_frame($sformatf("write_%0d", i), OP_WRITE, wr_addr, wr_data);
      end
      for (int a = 0; a < 2**ADDR_W; a++) begin
         rd_addr = addr_t'(a);
         if (model_written[rd_addr]) begin
            run_frame($sformatf("read_%02h", rd_addr), OP_READ, rd_addr, '0);
         end
      end

      bad.fields.opcode  = 8'hA5;
      bad.fields.addr    = 8'h10;
      bad.fields.data_hi = 8'h12;
      bad.fields.data_lo = 8'h34;
      send_frame(bad);
      check_idle("illegal_opcode", 2 * FRAME_CYC);
      check_trap("illegal_opcode", 1'b1, trap_o);

      @(posedge clk_i);
      #1;
      apply_reset();
      @(negedge clk_i);
      check_trap("trap_cleared", 1'b0, trap_o);
      run_frame("write_after_reset", OP_WRITE, group_addr, 16'h0F1E);
      run_frame("read_after_reset", OP_READ, group_addr, '0);

      repeat (4 * CLKS_PER_BIT) @(negedge clk_i);
      if (act_q.size() != 0) begin
         $display("%0d unexpected bytes came out on txd", act_q.size());
         protocol_cnt++;
      end
      $display("errors: mismatch %0d, missing %0d, protocol %0d",
               mismatch_cnt, missing_cnt, protocol_cnt);
      if (mismatch_cnt + missing_cnt + protocol_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* all.f */
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/reset_pulse_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_ctrl.sv
hw/ext_mem.sv
hw/soc_fpga_wrapper.sv
tb/soc_assert.sv
tb/tb_soc.sv

/* run.sh */
#!/bin/sh
# build and run the soc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_soc -Mdir obj_dir -o sim_soc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_soc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
   exit 0
fi
exit 1
